// ==== Bender.yml ====
package:
  name: rvcore

sources:
  - include_dirs:
      - include
    files:
      - hdl/rvCorePkg.sv
      - hdl/rvDecoder.sv
      - hdl/rvRegFile.sv
      - hdl/rvAlu.sv
      - hdl/rvHazardUnit.sv
      - hdl/rvCore.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tbRvCore.sv

// ==== flist.f ====
+incdir+include
hdl/rvCorePkg.sv
hdl/rvDecoder.sv
hdl/rvRegFile.sv
hdl/rvAlu.sv
hdl/rvHazardUnit.sv
hdl/rvCore.sv
testbench/tbRvCore.sv

// ==== hdl/rvAlu.sv ====
`timescale 1ns/10ps
`include "rvCore_params.svh"

module rvAlu (
	input  rvCorePkg::aluOp_t op,
	input  logic [`RV_XLEN-1:0] a,
	input  logic [`RV_XLEN-1:0] b,
	output logic [`RV_XLEN-1:0] y,
	output logic zero
);
	import rvCorePkg::*;

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (op)
			ALU_ADD: y = a + b;
			ALU_SUB: y = a - b;
			ALU_AND: y = a & b;
			ALU_OR: y = a | b;
			ALU_XOR: y = a ^ b;
			ALU_SLL: y = a << shamt;
			ALU_SRL: y = a >> shamt;
			ALU_SRA: y = $signed(a) >>> shamt;
			ALU_SLT: y = {{(`RV_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			ALU_SLTU: y = {{(`RV_XLEN-1){1'b0}}, a < b};
			default: y = '0;
		endcase
	end

	// used with SUB for the branch compare
	assign zero = (y == '0);

endmodule

// ==== hdl/rvCore.sv ====
`timescale 1ns/10ps
`include "rvCore_params.svh"

module rvCore (
	input  logic clk,
	input  logic rst,
	input  logic [`RV_XLEN-1:0] instrF,
	input  logic [`RV_XLEN-1:0] readDataM,
	output logic [`RV_XLEN-1:0] pcF,
	output logic [`RV_XLEN-1:0] aluResultM,
	output logic [`RV_XLEN-1:0] writeDataM,
	output logic memWriteM,
	output logic illegalD
);
	import rvCorePkg::*;

	// fetch and decode
	logic [`RV_XLEN-1:0] pcPlus4F;
	logic [`RV_XLEN-1:0] pcNextF;
	logic [`RV_XLEN-1:0] instrD;
	logic [`RV_XLEN-1:0] pcD;
	logic [`RV_REGW-1:0] rs1D;
	logic [`RV_REGW-1:0] rs2D;
	logic [`RV_REGW-1:0] rdD;
	logic [`RV_XLEN-1:0] rd1D;
	logic [`RV_XLEN-1:0] rd2D;
	logic [`RV_XLEN-1:0] immExtD;
	logic regWriteD;
	logic memWriteD;
	logic branchD;
	logic branchNeD;
	logic jumpD;
	logic aluSrcImmD;
	resultSrc_t resultSrcD;
	aluOp_t aluOpD;

	// execute
	logic regWriteE;
	logic memWriteE;
	logic branchE;
	logic branchNeE;
	logic jumpE;
	logic aluSrcImmE;
	resultSrc_t resultSrcE;
	aluOp_t aluOpE;
	logic [`RV_XLEN-1:0] rd1E;
	logic [`RV_XLEN-1:0] rd2E;
	logic [`RV_XLEN-1:0] immExtE;
	logic [`RV_XLEN-1:0] pcE;
	logic [`RV_REGW-1:0] rs1E;
	logic [`RV_REGW-1:0] rs2E;
	logic [`RV_REGW-1:0] rdE;
	logic [`RV_XLEN-1:0] srcAE;
	logic [`RV_XLEN-1:0] srcBE;
	logic [`RV_XLEN-1:0] writeDataE;
	logic [`RV_XLEN-1:0] aluResultE;
	logic [`RV_XLEN-1:0] pcTargetE;
	logic [`RV_XLEN-1:0] pcPlus4E;
	logic zeroE;
	logic pcSrcE;

	// memory and writeback
	logic regWriteM;
	resultSrc_t resultSrcM;
	logic [`RV_XLEN-1:0] pcPlus4M;
	logic [`RV_REGW-1:0] rdM;
	logic regWriteW;
	resultSrc_t resultSrcW;
	logic [`RV_XLEN-1:0] aluResultW;
	logic [`RV_XLEN-1:0] readDataW;
	logic [`RV_XLEN-1:0] pcPlus4W;
	logic [`RV_REGW-1:0] rdW;
	logic [`RV_XLEN-1:0] resultW;

	// hazard control
	logic stallF;
	logic stallD;
	logic flushD;
	logic flushE;
	fwdSel_t fwdA;
	fwdSel_t fwdB;

	function automatic logic [`RV_XLEN-1:0] fwdMux(input fwdSel_t sel,
			input logic [`RV_XLEN-1:0] regVal, input logic [`RV_XLEN-1:0] memVal,
			input logic [`RV_XLEN-1:0] wbVal);
		case (sel)
			FWD_MEM: return memVal;
			FWD_WB: return wbVal;
			default: return regVal;
		endcase
	endfunction

	// fetch
	assign pcPlus4F = pcF + `RV_XLEN'd4;
	assign pcNextF = pcSrcE ? pcTargetE : pcPlus4F;

	always_ff @(posedge clk) begin
		if (rst) begin
			pcF <= `RV_RESET_PC;
		end else if (!stallF) begin
			pcF <= pcNextF;
		end
	end

	// fetch/decode register, a zero word is a bubble
	always_ff @(posedge clk) begin
		if (rst || flushD) begin
			instrD <= '0;
		end else if (!stallD) begin
			instrD <= instrF;
		end
	end

	always_ff @(posedge clk) begin
		if (!stallD) begin
			pcD <= pcF;
		end
	end

	// decode
	assign rs1D = instrD[19:15];
	assign rs2D = instrD[24:20];
	assign rdD = instrD[11:7];

	rvDecoder decoder (
		.instrD(instrD),
		.regWrite(regWriteD),
		.memWrite(memWriteD),
		.branch(branchD),
		.branchNe(branchNeD),
		.jump(jumpD),
		.aluSrcImm(aluSrcImmD),
		.resultSrc(resultSrcD),
		.aluOp(aluOpD),
		.immExt(immExtD),
		.illegal(illegalD)
	);

	rvRegFile regFile (
		.clk(clk),
		.rst(rst),
		.rs1(rs1D),
		.rs2(rs2D),
		.rd1(rd1D),
		.rd2(rd2D),
		.we(regWriteW),
		.rd(rdW),
		.wd(resultW)
	);

	// decode/execute register
	always_ff @(posedge clk) begin
		if (rst || flushE) begin
			regWriteE <= 1'b0;
			memWriteE <= 1'b0;
			branchE <= 1'b0;
			branchNeE <= 1'b0;
			jumpE <= 1'b0;
			aluSrcImmE <= 1'b0;
			resultSrcE <= RES_ALU;
			aluOpE <= ALU_ADD;
		end else begin
			regWriteE <= regWriteD;
			memWriteE <= memWriteD;
			branchE <= branchD;
			branchNeE <= branchNeD;
			jumpE <= jumpD;
			aluSrcImmE <= aluSrcImmD;
			resultSrcE <= resultSrcD;
			aluOpE <= aluOpD;
		end
	end

	always_ff @(posedge clk) begin
		rd1E <= rd1D;
		rd2E <= rd2D;
		immExtE <= immExtD;
		pcE <= pcD;
		rs1E <= rs1D;
		rs2E <= rs2D;
		rdE <= rdD;
	end

	// execute
	assign srcAE = fwdMux(fwdA, rd1E, aluResultM, resultW);
	assign writeDataE = fwdMux(fwdB, rd2E, aluResultM, resultW);
	assign srcBE = aluSrcImmE ? immExtE : writeDataE;

	rvAlu alu (
		.op(aluOpE),
		.a(srcAE),
		.b(srcBE),
		.y(aluResultE),
		.zero(zeroE)
	);

	assign pcTargetE = pcE + immExtE;
	assign pcPlus4E = pcE + `RV_XLEN'd4;
	// BEQ wants zero set, BNE wants it clear
	assign pcSrcE = (branchE & (zeroE ^ branchNeE)) | jumpE;

	// execute/memory register
	always_ff @(posedge clk) begin
		if (rst) begin
			regWriteM <= 1'b0;
			memWriteM <= 1'b0;
			resultSrcM <= RES_ALU;
		end else begin
			regWriteM <= regWriteE;
			memWriteM <= memWriteE;
			resultSrcM <= resultSrcE;
		end
	end

	always_ff @(posedge clk) begin
		aluResultM <= aluResultE;
		writeDataM <= writeDataE;
		pcPlus4M <= pcPlus4E;
		rdM <= rdE;
	end

	// memory/writeback register
	always_ff @(posedge clk) begin
		if (rst) begin
			regWriteW <= 1'b0;
			resultSrcW <= RES_ALU;
		end else begin
			regWriteW <= regWriteM;
			resultSrcW <= resultSrcM;
		end
	end

	always_ff @(posedge clk) begin
		aluResultW <= aluResultM;
		readDataW <= readDataM;
		pcPlus4W <= pcPlus4M;
		rdW <= rdM;
	end

	// writeback
	always_comb begin
		case (resultSrcW)
			RES_MEM: resultW = readDataW;
			RES_PC4: resultW = pcPlus4W;
			default: resultW = aluResultW;
		endcase
	end

	rvHazardUnit hazard (
		.rs1D(rs1D),
		.rs2D(rs2D),
		.rs1E(rs1E),
		.rs2E(rs2E),
		.rdE(rdE),
		.rdM(rdM),
		.rdW(rdW),
		.loadE(resultSrcE == RES_MEM),
		.regWriteM(regWriteM),
		.regWriteW(regWriteW),
		.pcSrcE(pcSrcE),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.stallF(stallF),
		.stallD(stallD),
		.flushD(flushD),
		.flushE(flushE)
	);

endmodule

// ==== hdl/rvCorePkg.sv ====
`include "rvCore_params.svh"

package rvCorePkg;

	// major opcodes kept by this core
	// the all-zero word is the pipeline bubble
	typedef enum logic [6:0] {
		OPC_NOP0   = 7'b0000000,
		OPC_LOAD   = 7'b0000011,
		OPC_OPIMM  = 7'b0010011,
		OPC_STORE  = 7'b0100011,
		OPC_OP     = 7'b0110011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111
	} opcode_t;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_SLL  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_SLT  = 4'd8,
		ALU_SLTU = 4'd9
	} aluOp_t;

	// writeback source
	typedef enum logic [1:0] {
		RES_ALU = 2'd0,
		RES_MEM = 2'd1,
		RES_PC4 = 2'd2
	} resultSrc_t;

	// execute operand source
	typedef enum logic [1:0] {
		FWD_REG = 2'd0,
		FWD_WB  = 2'd1,
		FWD_MEM = 2'd2
	} fwdSel_t;

endpackage

// ==== hdl/rvDecoder.sv ====
`timescale 1ns/10ps
`include "rvCore_params.svh"

module rvDecoder (
	input  logic [`RV_XLEN-1:0] instrD,
	output logic regWrite,
	output logic memWrite,
	output logic branch,
	output logic branchNe,
	output logic jump,
	output logic aluSrcImm,
	output rvCorePkg::resultSrc_t resultSrc,
	output rvCorePkg::aluOp_t aluOp,
	output logic [`RV_XLEN-1:0] immExt,
	output logic illegal
);
	import rvCorePkg::*;

	opcode_t opc;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic altOp;
	logic f7Alt;
	logic shiftImm;
	aluOp_t aluFunc;
	logic [`RV_XLEN-1:0] immI;
	logic [`RV_XLEN-1:0] immS;
	logic [`RV_XLEN-1:0] immB;
	logic [`RV_XLEN-1:0] immJ;
	logic [`RV_XLEN-1:0] immSh;

	assign opc = opcode_t'(instrD[6:0]);
	assign funct3 = instrD[14:12];
	assign funct7 = instrD[31:25];
	assign shiftImm = (funct3[1:0] == 2'b01);

	assign immI = {{(`RV_XLEN-12){instrD[31]}}, instrD[31:20]};
	assign immS = {{(`RV_XLEN-12){instrD[31]}}, instrD[31:25], instrD[11:7]};
	assign immB = {{(`RV_XLEN-12){instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};
	assign immJ = {{(`RV_XLEN-20){instrD[31]}}, instrD[19:12], instrD[20], instrD[30:21], 1'b0};
	// shamt form, upper bits are funct7
	assign immSh = {{(`RV_XLEN-5){1'b0}}, instrD[24:20]};

	// funct7 bit 5 selects SUB only for register ops, SRA for both forms
	assign altOp = funct7[5] & ((opc == OPC_OP) | (funct3 == 3'b101));
	// 0x20 is only legal on the ADD/SUB and shift-right slots
	assign f7Alt = (funct7 == 7'h20) && (funct3 == 3'b000 || funct3 == 3'b101);

	// alu decoder
	always_comb begin
		case (funct3)
			3'b000: aluFunc = altOp ? ALU_SUB : ALU_ADD;
			3'b001: aluFunc = ALU_SLL;
			3'b010: aluFunc = ALU_SLT;
			3'b011: aluFunc = ALU_SLTU;
			3'b100: aluFunc = ALU_XOR;
			3'b101: aluFunc = altOp ? ALU_SRA : ALU_SRL;
			3'b110: aluFunc = ALU_OR;
			default: aluFunc = ALU_AND;
		endcase
	end

	// main decoder
	always_comb begin
		regWrite = 1'b0;
		memWrite = 1'b0;
		branch = 1'b0;
		branchNe = 1'b0;
		jump = 1'b0;
		aluSrcImm = 1'b0;
		resultSrc = RES_ALU;
		aluOp = ALU_ADD;
		immExt = immI;
		illegal = 1'b0;
		case (opc)
			OPC_OP: begin
				regWrite = 1'b1;
				aluOp = aluFunc;
				illegal = !(funct7 == 7'h00 || f7Alt);
			end
			OPC_OPIMM: begin
				regWrite = 1'b1;
				aluSrcImm = 1'b1;
				aluOp = aluFunc;
				immExt = shiftImm ? immSh : immI;
				illegal = shiftImm && !(funct7 == 7'h00 || f7Alt);
			end
			OPC_LOAD: begin
				regWrite = 1'b1;
				aluSrcImm = 1'b1;
				resultSrc = RES_MEM;
				illegal = (funct3 != 3'b010);
			end
			OPC_STORE: begin
				memWrite = 1'b1;
				aluSrcImm = 1'b1;
				immExt = immS;
				illegal = (funct3 != 3'b010);
			end
			OPC_BRANCH: begin
				// compare by subtraction, BNE is funct3 001
				branch = 1'b1;
				branchNe = funct3[0];
				aluOp = ALU_SUB;
				immExt = immB;
				illegal = (funct3[2:1] != 2'b00);
			end
			OPC_JAL: begin
				regWrite = 1'b1;
				jump = 1'b1;
				resultSrc = RES_PC4;
				immExt = immJ;
			end
			OPC_NOP0: illegal = (instrD != '0);
			default: illegal = 1'b1;
		endcase
		// an unknown encoding moves through as a bubble
		if (illegal) begin
			regWrite = 1'b0;
			memWrite = 1'b0;
			branch = 1'b0;
			branchNe = 1'b0;
			jump = 1'b0;
		end
	end

endmodule

// ==== hdl/rvHazardUnit.sv ====
`timescale 1ns/10ps
`include "rvCore_params.svh"

module rvHazardUnit (
	input  logic [`RV_REGW-1:0] rs1D,
	input  logic [`RV_REGW-1:0] rs2D,
	input  logic [`RV_REGW-1:0] rs1E,
	input  logic [`RV_REGW-1:0] rs2E,
	input  logic [`RV_REGW-1:0] rdE,
	input  logic [`RV_REGW-1:0] rdM,
	input  logic [`RV_REGW-1:0] rdW,
	input  logic loadE,
	input  logic regWriteM,
	input  logic regWriteW,
	input  logic pcSrcE,
	output rvCorePkg::fwdSel_t fwdA,
	output rvCorePkg::fwdSel_t fwdB,
	output logic stallF,
	output logic stallD,
	output logic flushD,
	output logic flushE
);
	import rvCorePkg::*;

	logic loadUse;

	// memory stage is younger, so it wins over writeback
	function automatic fwdSel_t pickSrc(input logic [`RV_REGW-1:0] rs);
		if (rs != '0 && regWriteM && rs == rdM) begin
			return FWD_MEM;
		end else if (rs != '0 && regWriteW && rs == rdW) begin
			return FWD_WB;
		end
		return FWD_REG;
	endfunction

	assign fwdA = pickSrc(rs1E);
	assign fwdB = pickSrc(rs2E);

	// load result is not ready until writeback
	assign loadUse = loadE && rdE != '0 && (rdE == rs1D || rdE == rs2D);

	assign stallF = loadUse;
	assign stallD = loadUse;
	assign flushD = pcSrcE;
	assign flushE = loadUse | pcSrcE;

endmodule

// ==== hdl/rvRegFile.sv ====
`timescale 1ns/10ps
`include "rvCore_params.svh"

module rvRegFile (
	input  logic clk,
	input  logic rst,
	input  logic [`RV_REGW-1:0] rs1,
	input  logic [`RV_REGW-1:0] rs2,
	output logic [`RV_XLEN-1:0] rd1,
	output logic [`RV_XLEN-1:0] rd2,
	input  logic we,
	input  logic [`RV_REGW-1:0] rd,
	input  logic [`RV_XLEN-1:0] wd
);
	logic [`RV_XLEN-1:0] regs [`RV_NREGS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `RV_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && rd != '0) begin
			regs[rd] <= wd;
		end
	end

	// x0 reads zero, a same-cycle write is passed straight through
	assign rd1 = (rs1 == '0) ? '0 : ((we && rd == rs1) ? wd : regs[rs1]);
	assign rd2 = (rs2 == '0) ? '0 : ((we && rd == rs2) ? wd : regs[rs2]);

endmodule

// ==== include/rvCore_params.svh ====
`ifndef RVCORE_PARAMS_SVH
`define RVCORE_PARAMS_SVH

// data path and address width
`define RV_XLEN 32

// architectural integer registers
`define RV_NREGS 32

// bits needed to name one register
`define RV_REGW 5

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

// ==== testbench/tbRvCore.sv ====
`timescale 1ns/10ps
`include "rvCore_params.svh"

module tbRvCore;
	import rvCorePkg::*;

	localparam int MemWords = 256;
	localparam int Timeout = 2000;
	localparam int RefSteps = 1000;
	localparam logic [6:0] OpcOp = 7'b0110011;
	localparam logic [6:0] OpcImm = 7'b0010011;
	localparam logic [6:0] OpcLoad = 7'b0000011;
	localparam logic [6:0] OpcStore = 7'b0100011;
	localparam logic [6:0] OpcBranch = 7'b1100011;
	localparam logic [6:0] OpcJal = 7'b1101111;
	localparam logic [`RV_XLEN-1:0] MarkerAddr = 32'h0000_03f0;

	logic clk = 1'b0;
	logic rst;
	logic [`RV_XLEN-1:0] instrF;
	logic [`RV_XLEN-1:0] readDataM;
	logic [`RV_XLEN-1:0] pcF;
	logic [`RV_XLEN-1:0] aluResultM;
	logic [`RV_XLEN-1:0] writeDataM;
	logic memWriteM;
	logic illegalD;

	logic [`RV_XLEN-1:0] imem [MemWords];
	logic [`RV_XLEN-1:0] dmem [MemWords];
	logic [`RV_XLEN-1:0] expAddr [$];
	logic [`RV_XLEN-1:0] expData [$];
	int progLen;
	int storeOff;
	int storeIdx;
	int storeErrors;
	int flagErrors;
	int pcErrors;
	int otherErrors;
	bit markerSeen;
	integer seed;

	rvCore uut (
		.clk(clk),
		.rst(rst),
		.instrF(instrF),
		.readDataM(readDataM),
		.pcF(pcF),
		.aluResultM(aluResultM),
		.writeDataM(writeDataM),
		.memWriteM(memWriteM),
		.illegalD(illegalD)
	);

	always #20 clk = ~clk;

	// initial data contents from the byte address
	function automatic logic [`RV_XLEN-1:0] fillWord(input int idx);
		logic [`RV_XLEN-1:0] addr;
		addr = idx * 4;
		return (addr * 32'h0001_0003) ^ 32'h6b2c_91e5;
	endfunction

	function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OpcOp};
	endfunction

	function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OpcStore};
	endfunction

	function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OpcBranch};
	endfunction

	function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OpcJal};
	endfunction

	task automatic emit(input logic [31:0] w);
		imem[progLen] = w;
		progLen++;
	endtask

	// each result goes to the next slot above the base in x10
	task automatic emitStore(input logic [4:0] rs2);
		emit(sType(storeOff[11:0], rs2, 5'd10));
		storeOff += 4;
	endtask

	task automatic emitR(input logic [6:0] f7, input logic [2:0] f3);
		emit(rType(f7, 5'd2, 5'd1, f3, 5'd5));
		emitStore(5'd5);
	endtask

	task automatic emitI(input logic [2:0] f3, input logic [11:0] imm);
		emit(iType(imm, 5'd1, f3, 5'd5, OpcImm));
		emitStore(5'd5);
	endtask

	task automatic buildProgram();
		logic [11:0] r1;
		logic [11:0] r2;
		logic [11:0] r3;
		logic [4:0] sh;
		r1 = $random(seed);
		r2 = $random(seed);
		r3 = $random(seed);
		sh = $random(seed);
		// x1 spans the full word and x2 is a small signed value
		emit(iType(r1, 5'd0, 3'b000, 5'd1, OpcImm));
		emit(iType(12'd19, 5'd1, 3'b001, 5'd1, OpcImm));
		emit(iType(r3, 5'd1, 3'b100, 5'd1, OpcImm));
		emit(iType(r2, 5'd0, 3'b000, 5'd2, OpcImm));
		emit(iType(12'h100, 5'd0, 3'b000, 5'd10, OpcImm));
		// register forms
		emitR(7'h00, 3'b000);
		emitR(7'h20, 3'b000);
		emitR(7'h00, 3'b111);
		emitR(7'h00, 3'b110);
		emitR(7'h00, 3'b100);
		emitR(7'h00, 3'b001);
		emitR(7'h00, 3'b101);
		emitR(7'h20, 3'b101);
		emitR(7'h00, 3'b010);
		emitR(7'h00, 3'b011);
		// immediate forms
		emitI(3'b000, $random(seed));
		emitI(3'b111, $random(seed));
		emitI(3'b110, $random(seed));
		emitI(3'b100, $random(seed));
		emitI(3'b010, $random(seed));
		emitI(3'b011, $random(seed));
		emitI(3'b001, {7'h00, sh});
		emitI(3'b101, {7'h00, sh});
		emitI(3'b101, {7'h20, sh});
		// dependent chain and then x0 as a destination
		emit(rType(7'h00, 5'd2, 5'd1, 3'b000, 5'd6));
		emit(rType(7'h00, 5'd1, 5'd6, 3'b000, 5'd7));
		emit(rType(7'h20, 5'd6, 5'd7, 3'b000, 5'd8));
		emit(iType(12'h07f, 5'd8, 3'b000, 5'd0, OpcImm));
		emit(rType(7'h00, 5'd8, 5'd0, 3'b000, 5'd9));
		emitStore(5'd9);
		emitStore(5'd0);
		emitStore(5'd8);
		// load-use once into the ALU and once into store data
		emit(iType(12'h200, 5'd10, 3'b010, 5'd12, OpcLoad));
		emit(rType(7'h00, 5'd1, 5'd12, 3'b000, 5'd13));
		emitStore(5'd13);
		emit(sType(12'h1a0, 5'd1, 5'd10));
		emit(iType(12'h1a0, 5'd10, 3'b010, 5'd14, OpcLoad));
		emitStore(5'd14);
		// control flow where the skipped stores must never show up
		emit(bType(13'd8, 5'd1, 5'd1, 3'b000));
		emitStore(5'd1);
		emit(bType(13'd8, 5'd1, 5'd1, 3'b001));
		emitStore(5'd2);
		emit(bType(13'd12, 5'd2, 5'd1, 3'b001));
		emitStore(5'd1);
		emitStore(5'd2);
		emit(bType(13'd8, 5'd2, 5'd1, 3'b000));
		emitStore(5'd6);
		emit(jType(21'd8, 5'd15));
		emitStore(5'd1);
		emitStore(5'd15);
		// marker store and then spin
		emit(iType(12'h05a, 5'd0, 3'b000, 5'd16, OpcImm));
		emit(sType(MarkerAddr[11:0], 5'd16, 5'd0));
		emit(jType(21'd0, 5'd0));
	endtask

	function automatic aluOp_t aluSelect(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: return alt ? ALU_SUB : ALU_ADD;
			3'b001: return ALU_SLL;
			3'b010: return ALU_SLT;
			3'b011: return ALU_SLTU;
			3'b100: return ALU_XOR;
			3'b101: return alt ? ALU_SRA : ALU_SRL;
			3'b110: return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	function automatic logic [`RV_XLEN-1:0] aluRef(input aluOp_t op,
			input logic [`RV_XLEN-1:0] a, input logic [`RV_XLEN-1:0] b);
		case (op)
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_AND: return a & b;
			ALU_OR: return a | b;
			ALU_XOR: return a ^ b;
			ALU_SLL: return a << b[4:0];
			ALU_SRL: return a >> b[4:0];
			ALU_SRA: return $unsigned($signed(a) >>> b[4:0]);
			ALU_SLT: return ($signed(a) < $signed(b)) ? 1 : 0;
			default: return (a < b) ? 1 : 0;
		endcase
	endfunction

	// architectural run of the program one instruction per step
	function automatic void runReference();
		logic [`RV_XLEN-1:0] x [`RV_NREGS];
		logic [`RV_XLEN-1:0] mem [MemWords];
		logic [`RV_XLEN-1:0] pc;
		logic [`RV_XLEN-1:0] pcNext;
		logic [`RV_XLEN-1:0] w;
		logic [`RV_XLEN-1:0] a;
		logic [`RV_XLEN-1:0] b;
		logic [`RV_XLEN-1:0] addr;
		logic [`RV_XLEN-1:0] immI;
		logic [`RV_XLEN-1:0] immS;
		logic [`RV_XLEN-1:0] immB;
		logic [`RV_XLEN-1:0] immJ;
		logic [4:0] rd;
		logic [2:0] f3;
		bit done;
		int steps;
		for (int i = 0; i < `RV_NREGS; i++) begin
			x[i] = '0;
		end
		for (int i = 0; i < MemWords; i++) begin
			mem[i] = fillWord(i);
		end
		pc = `RV_RESET_PC;
		done = 1'b0;
		steps = 0;
		while (!done && steps < RefSteps) begin
			w = imem[pc[9:2]];
			rd = w[11:7];
			f3 = w[14:12];
			a = x[w[19:15]];
			b = x[w[24:20]];
			immI = {{(`RV_XLEN-12){w[31]}}, w[31:20]};
			immS = {{(`RV_XLEN-12){w[31]}}, w[31:25], w[11:7]};
			immB = {{(`RV_XLEN-12){w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
			immJ = {{(`RV_XLEN-20){w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			pcNext = pc + 4;
			case (w[6:0])
				OpcOp: x[rd] = aluRef(aluSelect(f3, w[30]), a, b);
				OpcImm: begin
					if (f3 == 3'b001 || f3 == 3'b101) begin
						x[rd] = aluRef(aluSelect(f3, w[30]), a, {27'd0, w[24:20]});
					end else begin
						x[rd] = aluRef(aluSelect(f3, 1'b0), a, immI);
					end
				end
				OpcLoad: begin
					addr = a + immI;
					x[rd] = mem[addr[9:2]];
				end
				OpcStore: begin
					addr = a + immS;
					mem[addr[9:2]] = b;
					expAddr.push_back(addr);
					expData.push_back(b);
					done = (addr == MarkerAddr);
				end
				OpcBranch: begin
					// funct3 bit 0 turns BEQ into BNE
					if ((a == b) != f3[0]) begin
						pcNext = pc + immB;
					end
				end
				OpcJal: begin
					x[rd] = pc + 4;
					pcNext = pc + immJ;
				end
				default: begin
					$display("reference model met an unknown opcode at pc %h", pc);
					otherErrors++;
					done = 1'b1;
				end
			endcase
			x[0] = '0;
			pc = pcNext;
			steps++;
		end
		if (!done) begin
			$display("reference model never reached the marker store");
			otherErrors++;
		end
	endfunction

	task automatic checkStore(input int idx, input logic [`RV_XLEN-1:0] addr,
			input logic [`RV_XLEN-1:0] data);
		if (idx >= expAddr.size()) begin
			$display("store number %0d at %0t to address %h was not expected", idx, $time,
				addr);
			storeErrors++;
		end else if (addr !== expAddr[idx] || data !== expData[idx]) begin
			$display("CHECK FAILED at %0t: store %0d wrote %h to %h, expected %h to %h",
				$time, idx, data, addr, expData[idx], expAddr[idx]);
			storeErrors++;
		end
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
			flagErrors++;
		end
	endtask

	task automatic checkPc(input logic [`RV_XLEN-1:0] got, input logic [`RV_XLEN-1:0] exp,
			input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
			pcErrors++;
		end
	endtask

	// memories answer a few ns after the edge that moved pcF and aluResultM
	always @(posedge clk) begin
		#2;
		instrF = imem[pcF[9:2]];
		readDataM = dmem[aluResultM[9:2]];
	end

	// store log and compare mid-cycle while the outputs are stable
	always @(negedge clk) begin
		if (rst) begin
			checkFlag(memWriteM, 1'b0, "memWriteM during reset");
			checkPc(pcF, `RV_RESET_PC, "pcF during reset");
		end else begin
			checkFlag(illegalD, 1'b0, "illegalD");
			if (memWriteM) begin
				checkStore(storeIdx, aluResultM, writeDataM);
				dmem[aluResultM[9:2]] = writeDataM;
				storeIdx++;
				if (aluResultM == MarkerAddr) begin
					markerSeen = 1'b1;
				end
			end
		end
	end

	initial begin
		int cycles;
		int total;
		rst = 1'b1;
		instrF = '0;
		readDataM = '0;
		seed = 32'h8f4a_7bb7;
		progLen = 0;
		storeOff = 0;
		storeIdx = 0;
		storeErrors = 0;
		flagErrors = 0;
		pcErrors = 0;
		otherErrors = 0;
		markerSeen = 1'b0;
		for (int i = 0; i < MemWords; i++) begin
			imem[i] = '0;
			dmem[i] = fillWord(i);
		end
		buildProgram();
		runReference();
		repeat (4) @(posedge clk);
		#2;
		rst = 1'b0;
		cycles = 0;
		while (!markerSeen && cycles < Timeout) begin
			@(posedge clk);
			cycles++;
		end
		if (!markerSeen) begin
			$display("timeout: the program never finished within %0d cycles", Timeout);
			otherErrors++;
		end else begin
			// any store from the spin loop would show up here
			repeat (8) @(posedge clk);
		end
		if (storeIdx != expAddr.size()) begin
			$display("CHECK FAILED at %0t: %0d stores seen, expected %0d", $time, storeIdx,
				expAddr.size());
			otherErrors++;
		end
		total = storeErrors + flagErrors + pcErrors + otherErrors;
		$display("errors: %0d store, %0d flag, %0d pc, %0d other", storeErrors, flagErrors,
			pcErrors, otherErrors);
		if (total == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule
